// File: hw/uart_pkg.sv
/*
  uart_pkg
  frame constants shared by the transmitter, receiver and testbench
  parity mode encoding, where bit 1 means a parity bit is present and bit 0 means odd
*/

package uart_pkg;

  // frame geometry
  localparam int data_bits  = 8;   // data bits per frame, lsb first
  localparam int oversample = 16;  // baud ticks per bit period

  // receiver samples mid-bit, start bit confirmed at this tick
  localparam int sample_tick = oversample / 2;

  // counter widths
  localparam int tick_w = $clog2(oversample);  // tick counter inside one bit
  localparam int bit_w  = $clog2(data_bits);   // data bit index

  // longest frame is start + data + parity + two stops
  localparam int max_frame_bits = 1 + data_bits + 1 + 2;

  // parity mode
  // 0 and 1 both mean no parity bit on the line
  typedef enum logic [1:0] {
    parity_none     = 2'd0,
    parity_none_alt = 2'd1,
    parity_even     = 2'd2,  // total count of ones is even
    parity_odd      = 2'd3   // total count of ones is odd
  } parity_t;

endpackage

// File: hw/baud_gen.sv
/*
  baud_gen
  free-running clock divider
  one-clock tick every clock_div clocks, 16x the bit rate
  shared by both serial directions
*/

module baud_gen #(
  parameter int clock_div = 4  // clocks per oversample tick, 2 or more
) (
  input  logic clock,
  input  logic reset,
  output logic tick    // one-clock pulse
);

  localparam int cnt_w = $clog2(clock_div);

  logic [cnt_w-1:0] div_cnt;  // position inside one tick period
  logic             wrap;     // last clock of the period

  assign wrap = (div_cnt == cnt_w'(clock_div - 1));

  // counter runs from reset and never stalls
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // registered so tick is clean for both consumers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tick <= 1'b0;
    end else begin
      tick <= wrap;  // high for exactly one clock per wrap
    end
  end

endmodule

// File: hw/uart_tx.sv
/*
  uart_tx
  transmit frame FSM: idle, start, data, parity, stop1, stop2
  shift register sends lsb first, parity latched when the byte is taken
  every frame bit lasts oversample ticks from baud_gen
*/

module uart_tx
  import uart_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tick,         // oversample tick
  input  logic                 tx_en,        // transmitter enable
  input  parity_t              parity_type,
  input  logic                 nstop,        // 0 one stop bit, 1 two
  input  logic [data_bits-1:0] data_in,
  input  logic                 data_valid,   // data_in is valid
  output logic                 txd,          // serial out, idles high
  output logic                 tx_rdy        // ready for a new byte
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop1,
    st_stop2
  } tx_state_t;

  tx_state_t state;

  logic [tick_w-1:0]    tick_cnt;   // ticks into the current bit
  logic [bit_w-1:0]     bit_cnt;    // data bits already sent
  logic                 aligned;    // first tick seen, start bit on the line
  logic [data_bits-1:0] shift_reg;  // byte being sent, bit 0 is on txd
  logic                 parity_bit; // parity for the byte in flight
  logic                 accept;     // byte taken this clock
  logic                 bit_end;    // last tick of the current bit

  assign accept  = tx_en && data_valid && (state == st_idle);
  assign bit_end = tick && aligned && (tick_cnt == tick_w'(oversample - 1));

  // bit timing
  // the frame waits for the first tick so the start bit is a full period
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tick_cnt <= '0;
      aligned  <= 1'b0;
    end else if (accept) begin
      tick_cnt <= '0;
      aligned  <= 1'b0;
    end else if (tick && state != st_idle) begin
      if (!aligned) begin
        aligned <= 1'b1;  // start bit begins here
      end else begin
        tick_cnt <= tick_cnt + 1'b1;  // wraps to 0 at the end of each bit
      end
    end
  end

  // frame sequencing
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_start;
            bit_cnt <= '0;
          end
        end
        st_start: begin
          if (bit_end) state <= st_data;
        end
        st_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_w'(data_bits - 1)) begin
              state <= parity_type[1] ? st_parity : st_stop1;  // parity only if bit 1 set
            end
          end
        end
        st_parity: begin
          if (bit_end) state <= st_stop1;
        end
        st_stop1: begin
          if (bit_end) state <= nstop ? st_stop2 : st_idle;  // single stop ends the frame
        end
        st_stop2: begin
          if (bit_end) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload, loaded on accept and shifted at each data bit end
  always_ff @(posedge clock) begin
    if (accept) begin
      shift_reg  <= data_in;
      parity_bit <= (^data_in) ^ parity_type[0];  // odd mode flips the xor
    end else if (bit_end && state == st_data) begin
      shift_reg <= {1'b0, shift_reg[data_bits-1:1]};
    end
  end

  // line level per state
  always_comb begin
    case (state)
      st_start:  txd = ~aligned;       // stays high until the first tick
      st_data:   txd = shift_reg[0];   // lsb first
      st_parity: txd = parity_bit;
      default:   txd = 1'b1;           // idle and stop bits
    endcase
  end

  assign tx_rdy = (state == st_idle);

endmodule

// File: hw/uart_rx.sv
/*
  uart_rx
  two-flop synchronizer and falling edge start detection
  FSM idle, start, data, parity, stop with mid-bit sampling
  running parity check and stop bit framing check
  rx_valid pulses once per frame with data and error flags
*/

module uart_rx
  import uart_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tick,         // oversample tick
  input  parity_t              parity_type,
  input  logic                 rxd,          // asynchronous serial in
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_valid,     // one clock per received frame
  output logic                 parity_err,   // parity bit disagreed
  output logic                 frame_err     // stop bit sampled low
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop
  } rx_state_t;

  rx_state_t state;

  logic                 rxd_meta;    // first synchronizer stage
  logic                 rxd_sync;    // safe to use
  logic                 rxd_prev;    // for edge detect
  logic                 fall;        // falling edge on the line
  logic [tick_w-1:0]    tick_cnt;    // ticks since last sample or edge
  logic [tick_w-1:0]    sample_at;   // tick count where the next sample lands
  logic                 sample;      // sample the line this clock
  logic [bit_w-1:0]     bit_cnt;     // data bits received
  logic [data_bits-1:0] shift_reg;   // bits shift in from the top
  logic                 parity_acc;  // ends at 0 when parity matches

  // synchronizer, reset to idle line level
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  assign fall = rxd_prev && !rxd_sync;

  // half a bit to the start sample, a full bit after that
  assign sample_at = (state == st_start) ? tick_w'(sample_tick - 1) : tick_w'(oversample - 1);
  assign sample    = tick && (tick_cnt == sample_at);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tick_cnt <= '0;
    end else if (state == st_idle || sample) begin
      tick_cnt <= '0;  // restart counting from each sample
    end else if (tick) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // frame sequencing and result outputs
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= st_idle;
      bit_cnt    <= '0;
      rx_valid   <= 1'b0;
      rx_data    <= '0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;  // pulse only
      case (state)
        st_idle: begin
          if (fall) state <= st_start;
        end
        st_start: begin
          if (sample) begin
            bit_cnt <= '0;
            state   <= rxd_sync ? st_idle : st_data;  // high at mid-bit is a glitch
          end
        end
        st_data: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_w'(data_bits - 1)) begin
              state <= parity_type[1] ? st_parity : st_stop;
            end
          end
        end
        st_parity: begin
          if (sample) state <= st_stop;
        end
        st_stop: begin
          if (sample) begin
            // only the first stop bit is checked, a second one reads as idle line
            state      <= st_idle;
            rx_valid   <= 1'b1;
            rx_data    <= shift_reg;
            parity_err <= parity_type[1] && parity_acc;
            frame_err  <= !rxd_sync;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data path, loaded fresh each frame
  always_ff @(posedge clock) begin
    if (state == st_start && sample) begin
      parity_acc <= parity_type[0];  // odd mode seeds with 1
    end else if (sample && (state == st_data || state == st_parity)) begin
      parity_acc <= parity_acc ^ rxd_sync;  // received parity bit cancels a match
    end
    if (state == st_data && sample) begin
      shift_reg <= {rxd_sync, shift_reg[data_bits-1:1]};  // lsb arrives first
    end
  end

endmodule

// File: hw/uart_top.sv
/*
  uart_top
  baud generator shared by transmitter and receiver
  clock_div set here and passed to the divider
  configuration levels fan out to both directions
*/

module uart_top
  import uart_pkg::*;
#(
  parameter int clock_div = 4  // clocks per oversample tick
) (
  input  logic                 clock,
  input  logic                 reset,
  // configuration, stable during a frame
  input  logic                 tx_en,
  input  parity_t              parity_type,
  input  logic                 nstop,
  // parallel transmit side
  input  logic [data_bits-1:0] data_in,
  input  logic                 data_valid,
  output logic                 tx_rdy,
  // serial line
  output logic                 txd,
  input  logic                 rxd,
  // parallel receive side
  output logic [data_bits-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 parity_err,
  output logic                 frame_err
);

  logic tick;  // shared oversample tick

  baud_gen #(
    .clock_div(clock_div)
  ) u_baud (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  uart_tx u_tx (
    .clock       (clock),
    .reset       (reset),
    .tick        (tick),
    .tx_en       (tx_en),
    .parity_type (parity_type),
    .nstop       (nstop),       // receiver ignores stop count
    .data_in     (data_in),
    .data_valid  (data_valid),
    .txd         (txd),
    .tx_rdy      (tx_rdy)
  );

  uart_rx u_rx (
    .clock       (clock),
    .reset       (reset),
    .tick        (tick),
    .parity_type (parity_type),
    .rxd         (rxd),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .parity_err  (parity_err),
    .frame_err   (frame_err)
  );

endmodule

// File: dv/uart_tb.sv
/*
  uart_tb
  directed testbench for uart_top, loopback or testbench-driven rxd
  tasks for sending, receiving, bit-banging frames and checking frame shape
  xorshift byte source, error and timeout counts, watchdog
*/

module uart_tb
  import uart_pkg::*;
;

  localparam int clock_div   = 4;
  localparam int bit_clocks  = oversample * clock_div;       // 64 clocks per bit
  localparam int frame_limit = (max_frame_bits + 2) * bit_clocks;
  localparam int n_frames    = 20 + 16 + 2 + 4;             // frames over all tests
  localparam int watchdog_time = n_frames * max_frame_bits * bit_clocks * 10 + 50000;

  logic                 clock;
  logic                 reset;
  logic                 tx_en;
  parity_t              parity_type;
  logic                 nstop;
  logic [data_bits-1:0] data_in;
  logic                 data_valid;
  logic                 tx_rdy;
  logic                 txd;
  logic                 rxd;
  logic [data_bits-1:0] rx_data;
  logic                 rx_valid;
  logic                 parity_err;
  logic                 frame_err;

  logic        loopback;   // 1 ties rxd to txd
  logic        line_drv;   // testbench serial line
  logic [31:0] rng;        // xorshift state
  int          errors;
  int          timeouts;
  int          rx_count;   // rx_valid pulses seen

  assign rxd = loopback ? txd : line_drv;

  uart_top #(
    .clock_div(clock_div)
  ) u_dut (
    .clock      (clock),
    .reset      (reset),
    .tx_en      (tx_en),
    .parity_type(parity_type),
    .nstop      (nstop),
    .data_in    (data_in),
    .data_valid (data_valid),
    .tx_rdy     (tx_rdy),
    .txd        (txd),
    .rxd        (rxd),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  always #5 clock = ~clock;  // period 10

  always @(negedge clock) begin
    if (rx_valid) rx_count++;  // pulse count sampled away from the edge
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bit that brings the count of ones to even or odd
  function automatic logic expected_parity(input logic [7:0] b, input parity_t p);
    logic ones_odd;
    ones_odd = ($countones(b) % 2) == 1;
    return (p == parity_odd) ? !ones_odd : ones_odd;
  endfunction

  // serial bits in line order with the start bit at bit 0 and idle high past the end
  function automatic logic [15:0] frame_bits(input logic [7:0] b, input parity_t p,
                                             input logic flip_par, input logic low_stop);
    logic [15:0] f;
    int          n;
    f = '1;
    f[0] = 1'b0;
    f[8:1] = b;
    n = 9;
    if (p[1]) begin
      f[n] = expected_parity(b, p) ^ flip_par;
      n++;
    end
    f[n] = ~low_stop;
    return f;
  endfunction

  // wrong value, logged with the time and counted
  task automatic report_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic random_byte(output logic [7:0] b);
    rng = xorshift32(rng);
    b = rng[7:0];
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clock);
    #1;
  endtask

  // all tasks start and end 1 unit after a rising edge
  task automatic send_byte(input logic [7:0] b);
    int cnt;
    cnt = 0;
    while (!tx_rdy && cnt < frame_limit) begin
      wait_clocks(1);
      cnt++;
    end
    if (!tx_rdy) begin
      $display("timeout: tx_rdy stayed low for %0d clocks before a send", frame_limit);
      timeouts++;
    end
    data_in    = b;
    data_valid = 1'b1;
    wait_clocks(1);       // taken on this edge
    data_valid = 1'b0;
  endtask

  task automatic wait_tx_idle();
    int cnt;
    cnt = 0;
    while (!tx_rdy && cnt < frame_limit) begin
      wait_clocks(1);
      cnt++;
    end
    if (!tx_rdy) begin
      $display("timeout: transmitter did not return to idle within %0d clocks", frame_limit);
      timeouts++;
    end
  endtask

  task automatic wait_rx(output logic got);
    int cnt;
    cnt = 0;
    while (!rx_valid && cnt < frame_limit) begin
      wait_clocks(1);
      cnt++;
    end
    got = rx_valid;
    if (!got) begin
      $display("timeout: no rx_valid within %0d clocks", frame_limit);
      timeouts++;
    end
  endtask

  task automatic drive_frame(input logic [15:0] bits, input int nbits);
    for (int i = 0; i < nbits; i++) begin
      line_drv = bits[i];
      wait_clocks(bit_clocks);
    end
    line_drv = 1'b1;  // back to idle
  endtask

  task automatic check_reset_state();
    assert (txd === 1'b1 && tx_rdy === 1'b1)
      else report_error($sformatf("txd/tx_rdy %b%b after reset", txd, tx_rdy));
    assert (rx_valid === 1'b0 && parity_err === 1'b0 && frame_err === 1'b0)
      else report_error("rx outputs not clear after reset");
    tx_en      = 1'b0;
    data_in    = 8'h5a;
    data_valid = 1'b1;  // must be ignored while disabled
    wait_clocks(1);
    data_valid = 1'b0;
    for (int i = 0; i < 32; i++) begin
      assert (txd === 1'b1 && tx_rdy === 1'b1)
        else report_error("disabled transmitter started a frame");
      wait_clocks(1);
    end
    tx_en = 1'b1;
  endtask

  task automatic check_loopback(input parity_t p, input logic two_stop, input int count);
    logic [7:0] b;
    logic       got;
    parity_type = p;
    nstop       = two_stop;
    for (int i = 0; i < count; i++) begin
      random_byte(b);
      send_byte(b);
      assert (tx_rdy === 1'b0)
        else report_error("tx_rdy high while frame busy");
      wait_rx(got);
      assert (!got || rx_data === b)
        else report_error($sformatf("rx_data %02h, expected %02h", rx_data, b));
      assert (!got || (parity_err === 1'b0 && frame_err === 1'b0))
        else report_error($sformatf("error flag set on clean frame %02h", b));
      // rx_valid comes at mid stop bit, the transmitter is still busy
      assert (!got || tx_rdy === 1'b0)
        else report_error("tx_rdy high before the stop bit ended");
      wait_tx_idle();
    end
  endtask

  task automatic check_frame_shape(input parity_t p, input logic two_stop, input logic [7:0] b);
    int cnt;
    int stop_start;
    int stop_len;
    int exp_len;
    parity_type = p;
    nstop       = two_stop;
    send_byte(b);
    cnt = 0;
    while (txd && cnt < bit_clocks) begin  // start edge comes within one tick
      wait_clocks(1);
      cnt++;
    end
    if (txd) begin
      $display("timeout: no start bit on txd after a send");
      timeouts++;
    end else begin
      wait_clocks(bit_clocks / 2);
      cnt = bit_clocks / 2;  // clocks since the start edge
      assert (txd === 1'b0)
        else report_error($sformatf("start bit reads %b", txd));
      for (int i = 0; i < data_bits; i++) begin
        wait_clocks(bit_clocks);
        cnt += bit_clocks;
        assert (txd === b[i])
          else report_error($sformatf("data bit %0d reads %b", i, txd));
      end
      if (p[1]) begin
        wait_clocks(bit_clocks);
        cnt += bit_clocks;
        assert (txd === expected_parity(b, p))
          else report_error($sformatf("parity bit reads %b", txd));
      end
      stop_start = cnt + bit_clocks / 2;
      for (int s = 0; s <= int'(two_stop); s++) begin
        wait_clocks(bit_clocks);
        cnt += bit_clocks;
        assert (txd === 1'b1)
          else report_error($sformatf("stop bit %0d reads 0", s + 1));
      end
      while (!tx_rdy && cnt < frame_limit) begin
        wait_clocks(1);
        cnt++;
      end
      stop_len = cnt - stop_start;
      exp_len  = two_stop ? 2 * bit_clocks : bit_clocks;
      assert (stop_len >= exp_len - clock_div && stop_len <= exp_len + clock_div)
        else report_error($sformatf("stop length %0d, expected %0d", stop_len, exp_len));
    end
    wait_clocks(bit_clocks);  // receiver back to idle
  endtask

  task automatic check_rx_errors();
    logic [7:0] b;
    logic       got;
    int         seen;
    loopback = 1'b0;
    nstop    = 1'b0;
    wait_clocks(bit_clocks);
    // flipped parity bit
    parity_type = parity_even;
    random_byte(b);
    fork
      drive_frame(frame_bits(b, parity_even, 1'b1, 1'b0), 11);
      wait_rx(got);
    join
    assert (!got || (parity_err === 1'b1 && frame_err === 1'b0 && rx_data === b))
      else report_error($sformatf("bad parity frame gave data %02h pe %b fe %b",
                                  rx_data, parity_err, frame_err));
    wait_clocks(bit_clocks);
    // low stop bit
    parity_type = parity_none;
    random_byte(b);
    fork
      drive_frame(frame_bits(b, parity_none, 1'b0, 1'b1), 10);
      wait_rx(got);
    join
    assert (!got || (frame_err === 1'b1 && rx_data === b))
      else report_error($sformatf("low stop frame gave data %02h fe %b", rx_data, frame_err));
    wait_clocks(bit_clocks);
    // start glitch of 5 ticks is shorter than the 8 tick confirm
    seen = rx_count;
    line_drv = 1'b0;
    wait_clocks(5 * clock_div);
    line_drv = 1'b1;
    wait_clocks(frame_limit);  // a false start would finish its frame in here
    assert (rx_count == seen)
      else report_error("short start pulse produced rx_valid");
    loopback = 1'b1;
  endtask

  initial begin
    #(watchdog_time);
    $display("timeout: watchdog expired before the tests finished");
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [7:0] b;
    clock       = 1'b0;
    reset       = 1'b1;
    tx_en       = 1'b0;
    parity_type = parity_none;
    nstop       = 1'b0;
    data_in     = '0;
    data_valid  = 1'b0;
    loopback    = 1'b1;
    line_drv    = 1'b1;
    rng         = 32'h6ade7a0f;
    errors      = 0;
    timeouts    = 0;
    rx_count    = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    check_reset_state();
    check_loopback(parity_none, 1'b0, 20);
    check_loopback(parity_even, 1'b1, 8);
    check_loopback(parity_odd, 1'b1, 8);
    random_byte(b);
    check_frame_shape(parity_even, 1'b0, b);
    random_byte(b);
    check_frame_shape(parity_odd, 1'b1, b);
    check_rx_errors();

    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/uart_pkg.sv
hw/baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
dv/uart_tb.sv
